/* build.f */
+incdir+logic
logic/aes_dec_pkg.sv
logic/aes_inv_sbox.sv
logic/aes_inv_sub_word.sv
logic/aes_inv_mix_columns.sv
logic/aes_decipher_ctrl.sv
logic/aes_decipher_datapath.sv
logic/aes_decipher_block.sv
verif/tb_aes_decipher.sv

/* Makefile */
TOP = tb_aes_decipher

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -qF '*** TEST PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log

/* verif/tb_aes_decipher.sv */
`include "aes_dec_macros.svh"

module tb_aes_decipher;

  timeunit 1ns;
  timeprecision 100ps;

  import aes_dec_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int NUM_RUNS   = 52;
  localparam logic [31:0] SEED = 32'h64d8f8bb;

  logic   clk;
  logic   reset_n;
  logic   next;
  logic   keylen;
  round_t round;
  block_t round_key;
  block_t block;
  block_t new_block;
  logic   ready;

  // Round keys served by index in the same cycle
  block_t key_table [0:14];
  byte_t  inv_sbox_tab [0:255];

  // Expected plaintext and round count per request
  block_t exp_q [$];
  int     n_q [$];

  int     errors;
  int     checked;
  bit     busy;
  int     lat;
  int     cur_n;
  block_t cur_exp;

  assign round_key = key_table[round];

  aes_decipher_block aes_decipher_block_i (
    .clk       (clk),
    .reset_n   (reset_n),
    .next      (next),
    .keylen    (keylen),
    .round     (round),
    .round_key (round_key),
    .block     (block),
    .new_block (new_block),
    .ready     (ready)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ----------------------------------------
  // Reference inverse cipher
  // ----------------------------------------

  // Shift and add multiply modulo the AES polynomial
  function automatic byte_t gf_mul(input byte_t a, input byte_t b);
    byte_t p;
    byte_t x;
    int    i;
    p = 8'h00;
    x = a;
    for (i = 0; i < 8; i++)
    begin
      if (b[i])
        p = p ^ x;
      x = {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
    end
    return p;
  endfunction

  // Inverse affine map followed by x^254 as the field inverse
  function automatic byte_t inv_sbox_value(input byte_t s);
    byte_t y;
    byte_t inv;
    int    i;
    y   = {s[6:0], s[7]} ^ {s[4:0], s[7:5]} ^ {s[1:0], s[7:2]} ^ 8'h05;
    inv = 8'h01;
    for (i = 0; i < 254; i++)
      inv = gf_mul(inv, y);
    return inv;
  endfunction

  // Row r rotates right by r positions
  // Source byte for each output byte in column-major order
  function automatic block_t inv_shift_rows(input block_t s);
    byte_t b [0:15];
    int    i;
    for (i = 0; i < 16; i++)
      b[i] = s[127 - 8*i -: 8];
    return {b[0],  b[13], b[10], b[7],
            b[4],  b[1],  b[14], b[11],
            b[8],  b[5],  b[2],  b[15],
            b[12], b[9],  b[6],  b[3]};
  endfunction

  function automatic block_t inv_mix(input block_t s);
    block_t o;
    byte_t  a [0:3];
    int     c;
    int     r;
    for (c = 0; c < 4; c++)
    begin
      for (r = 0; r < 4; r++)
        a[r] = s[127 - 8*(4*c + r) -: 8];
      // Rotating rows of 14 11 13 9
      for (r = 0; r < 4; r++)
        o[127 - 8*(4*c + r) -: 8] = gf_mul(a[r], 8'd14) ^ gf_mul(a[(r + 1) % 4], 8'd11)
                                  ^ gf_mul(a[(r + 2) % 4], 8'd13) ^ gf_mul(a[(r + 3) % 4], 8'd9);
    end
    return o;
  endfunction

  function automatic block_t ref_decrypt(input block_t ct, input block_t keys [0:14],
                                         input int n);
    block_t s;
    int     r;
    int     i;
    s = ct ^ keys[n];
    for (r = n - 1; r >= 0; r--)
    begin
      s = inv_shift_rows(s);
      for (i = 0; i < 16; i++)
        s[127 - 8*i -: 8] = inv_sbox_tab[s[127 - 8*i -: 8]];
      s = s ^ keys[r];
      if (r > 0)
        s = inv_mix(s);
    end
    return s;
  endfunction

  function automatic block_t rand_block();
    return {$urandom(), $urandom(), $urandom(), $urandom()};
  endfunction

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------

  // One request with optional stray next pulses while busy
  task automatic run_request(input logic kl, input bit pulses);
    block_t keys [0:14];
    block_t ct;
    int     n;
    int     i;
    int     cycles;
    n = kl ? `AES_256_ROUNDS : `AES_128_ROUNDS;
    for (i = 0; i <= 14; i++)
      keys[i] = (i <= n) ? rand_block() : '0;
    ct = rand_block();
    exp_q.push_back(ref_decrypt(ct, keys, n));
    n_q.push_back(n);
    @(posedge clk);
    for (i = 0; i <= 14; i++)
      key_table[i] <= keys[i];
    next   <= 1'b1;
    keylen <= kl;
    block  <= ct;
    // Accepting edge
    @(posedge clk);
    next <= 1'b0;
    cycles = 0;
    @(negedge clk);
    while (!ready)
    begin
      cycles++;
      @(posedge clk);
      // Stray pulses well before the end of the run
      next <= pulses && cycles < 40 && (cycles % 5 == 2);
      @(negedge clk);
    end
  endtask

  initial
  begin
    int i;
    void'($urandom(SEED));
    for (i = 0; i < 256; i++)
      inv_sbox_tab[i] = inv_sbox_value(byte_t'(i));
    for (i = 0; i <= 14; i++)
      key_table[i] = '0;
    errors  = 0;
    checked = 0;
    busy    = 1'b0;
    reset_n = 1'b0;
    next    = 1'b0;
    keylen  = 1'b0;
    block   = '0;
    repeat (4) @(posedge clk);
    reset_n <= 1'b1;

    // Reset values
    @(negedge clk);
    assert (ready === 1'b1)
    else
    begin
      $display("FAIL ready: got %h, expected %h", ready, 1'b1);
      errors++;
    end
    assert (round === 4'h0)
    else
    begin
      $display("FAIL round: got %h, expected %h", round, 4'h0);
      errors++;
    end
    assert (new_block === 128'h0)
    else
    begin
      $display("FAIL new_block: got %h, expected %h", new_block, 128'h0);
      errors++;
    end

    for (i = 0; i < 20; i++)
      run_request(1'b0, 1'b0);
    for (i = 0; i < 20; i++)
      run_request(1'b1, 1'b0);
    // Ignored next pulses
    for (i = 0; i < 4; i++)
      run_request(i[0], 1'b1);
    // Back to back with alternating key length
    for (i = 0; i < 8; i++)
      run_request(i[0], 1'b0);

    repeat (2) @(posedge clk);
    assert (checked == NUM_RUNS)
    else
    begin
      $display("Only %0d of %0d results were checked", checked, NUM_RUNS);
      errors++;
    end
    $display("Results checked: %0d, errors: %0d", checked, errors);
    if (errors == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

  // ----------------------------------------
  // Checker
  // ----------------------------------------
  always @(negedge clk)
  begin
    if (reset_n && !ready)
    begin
      // First busy cycle after acceptance
      if (!busy)
      begin
        busy = 1'b1;
        lat  = 0;
        if (exp_q.size() == 0)
        begin
          $display("Ready fell with no request pending");
          errors++;
          cur_n   = `AES_256_ROUNDS;
          cur_exp = '0;
        end
        else
        begin
          cur_exp = exp_q.pop_front();
          cur_n   = n_q.pop_front();
        end
        assert (round == round_t'(cur_n))
        else
        begin
          $display("FAIL round: got %h, expected %h", round, round_t'(cur_n));
          errors++;
        end
      end
      lat++;
      assert (round <= round_t'(cur_n))
      else
      begin
        $display("FAIL round: got %h, above %h", round, round_t'(cur_n));
        errors++;
      end
    end
    else if (reset_n && busy)
    begin
      busy = 1'b0;
      checked++;
      assert (new_block == cur_exp)
      else
      begin
        $display("FAIL new_block: got %h, expected %h", new_block, cur_exp);
        errors++;
      end
      assert (lat == 7 * cur_n)
      else
      begin
        $display("Ready rose after %0d cycles instead of %0d", lat, 7 * cur_n);
        errors++;
      end
    end
  end

  // Watchdog allows 120 cycles per request plus margin
  initial
  begin
    #((NUM_RUNS * 120 + 50) * CLK_PERIOD);
    $display("Timeout, the run did not finish in time");
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

/* logic/aes_decipher_block.sv */
module aes_decipher_block (
  input  logic                clk,
  input  logic                reset_n,
  input  logic                next,
  input  logic                keylen,
  output aes_dec_pkg::round_t round,
  input  aes_dec_pkg::block_t round_key,
  input  aes_dec_pkg::block_t block,
  output aes_dec_pkg::block_t new_block,
  output logic                ready
);

  import aes_dec_pkg::*;

  // Controller to datapath
  block_upd_t upd;
  word_idx_t  word_idx;

  // FSM, round and column counters
  aes_decipher_ctrl ctrl_i (
    .clk      (clk),
    .reset_n  (reset_n),
    .next     (next),
    .keylen   (keylen),
    .round    (round),
    .word_idx (word_idx),
    .upd      (upd),
    .ready    (ready)
  );

  // State register and round transforms
  aes_decipher_datapath datapath_i (
    .clk       (clk),
    .reset_n   (reset_n),
    .upd       (upd),
    .word_idx  (word_idx),
    .block     (block),
    .round_key (round_key),
    .new_block (new_block)
  );

endmodule

/* logic/aes_decipher_datapath.sv */
module aes_decipher_datapath (
  input  logic                    clk,
  input  logic                    reset_n,
  input  aes_dec_pkg::block_upd_t upd,
  input  aes_dec_pkg::word_idx_t  word_idx,
  input  aes_dec_pkg::block_t     block,
  input  aes_dec_pkg::block_t     round_key,
  output aes_dec_pkg::block_t     new_block
);

  import aes_dec_pkg::*;

  block_t block_reg;
  block_t block_nxt;
  block_t shifted;
  block_t subbed;
  block_t mixed;
  block_t key_in;
  block_t keyed;

  // ----------------------------------------
  // InvShiftRows, pure wiring
  // ----------------------------------------
  // Row r moves right by r columns
  for (genvar c = 0; c < 4; c++)
  begin : g_col
    for (genvar r = 0; r < 4; r++)
    begin : g_row
      assign shifted[127 - 8*(4*c + r) -: 8] =
        block_reg[127 - 8*(4*((c + 4 - r) % 4) + r) -: 8];
    end
  end

  // One column per cycle
  aes_inv_sub_word inv_sub_word_i (
    .state    (block_reg),
    .word_idx (word_idx),
    .result   (subbed)
  );

  aes_inv_mix_columns inv_mix_columns_i (
    .state  (block_reg),
    .result (mixed)
  );

  // AddRoundKey, ciphertext on the init step and state otherwise
  assign key_in = (upd == upd_init_key) ? block : block_reg;
  assign keyed  = key_in ^ round_key;

  // Next state select
  always_comb
  begin
    case (upd)
      upd_init_key: block_nxt = keyed;
      upd_shift:    block_nxt = shifted;
      upd_sbox:     block_nxt = subbed;
      upd_key:      block_nxt = keyed;
      upd_mix:      block_nxt = mixed;
      default:      block_nxt = block_reg;
    endcase
  end

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      block_reg <= '0;
    else
      block_reg <= block_nxt;
  end

  // Plaintext once ready is back
  assign new_block = block_reg;

endmodule

/* logic/aes_decipher_ctrl.sv */
`include "aes_dec_macros.svh"

module aes_decipher_ctrl (
  input  logic                    clk,
  input  logic                    reset_n,
  input  logic                    next,
  input  logic                    keylen,
  output aes_dec_pkg::round_t     round,
  output aes_dec_pkg::word_idx_t  word_idx,
  output aes_dec_pkg::block_upd_t upd,
  output logic                    ready
);

  import aes_dec_pkg::*;

  dec_state_t state;
  round_t     num_rounds;

  // Last round key index for the key length
  assign num_rounds = keylen ? round_t'(`AES_256_ROUNDS) : round_t'(`AES_128_ROUNDS);

  // ----------------------------------------
  // Step sequencing
  // ----------------------------------------
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state    <= dec_idle;
      round    <= '0;
      word_idx <= '0;
      ready    <= 1'b1;
    end
    else
    begin
      case (state)
        dec_idle:
        begin
          // Start from the last round key
          if (next)
          begin
            round <= num_rounds;
            ready <= 1'b0;
            state <= dec_init;
          end
        end
        dec_init:
        begin
          // Initial AddRoundKey consumes key N
          round <= round - 1'b1;
          state <= dec_shift;
        end
        dec_shift:
          state <= dec_sbox;
        dec_sbox:
        begin
          // Counter wraps to 0 after the last column
          word_idx <= word_idx + 1'b1;
          if (word_idx == word_idx_t'(`AES_SBOX_STEPS - 1))
            state <= dec_key;
        end
        dec_key:
        begin
          // Key 0 closes the run, no InvMixColumns
          if (round == '0)
          begin
            ready <= 1'b1;
            state <= dec_idle;
          end
          else
          begin
            round <= round - 1'b1;
            state <= dec_mix;
          end
        end
        dec_mix:
          state <= dec_shift;
        default:
          state <= dec_idle;
      endcase
    end
  end

  // Datapath update source follows the step
  always_comb
  begin
    case (state)
      dec_init:  upd = upd_init_key;
      dec_shift: upd = upd_shift;
      dec_sbox:  upd = upd_sbox;
      dec_key:   upd = upd_key;
      dec_mix:   upd = upd_mix;
      default:   upd = upd_hold;
    endcase
  end

  // ----------------------------------------
  // Checks
  // ----------------------------------------

  // Key index stays inside the AES-256 schedule
  a_round_range: assert property (@(posedge clk) disable iff (!reset_n)
    round <= round_t'(`AES_256_ROUNDS));

  // Ready only while waiting for a request
  a_ready_idle: assert property (@(posedge clk) disable iff (!reset_n)
    ready |-> state == dec_idle);

  // Column index moves only on substitution steps
  a_word_step: assert property (@(posedge clk) disable iff (!reset_n)
    word_idx != $past(word_idx) |-> $past(state) == dec_sbox);

endmodule

/* logic/aes_inv_mix_columns.sv */
module aes_inv_mix_columns (
  input  aes_dec_pkg::block_t state,
  output aes_dec_pkg::block_t result
);

  import aes_dec_pkg::*;

  // ----------------------------------------
  // Per column product with the matrix
  //   14 11 13  9
  //    9 14 11 13
  //   13  9 14 11
  //   11 13  9 14
  // ----------------------------------------
  for (genvar c = 0; c < 4; c++)
  begin : g_col
    byte_t b0;
    byte_t b1;
    byte_t b2;
    byte_t b3;

    // Rows 0 to 3 of column c
    assign b0 = state[127 - 32*c -: 8];
    assign b1 = state[119 - 32*c -: 8];
    assign b2 = state[111 - 32*c -: 8];
    assign b3 = state[103 - 32*c -: 8];

    assign result[127 - 32*c -: 8] = gm14(b0) ^ gm11(b1) ^ gm13(b2) ^ gm9(b3);
    assign result[119 - 32*c -: 8] = gm9(b0) ^ gm14(b1) ^ gm11(b2) ^ gm13(b3);
    assign result[111 - 32*c -: 8] = gm13(b0) ^ gm9(b1) ^ gm14(b2) ^ gm11(b3);
    assign result[103 - 32*c -: 8] = gm11(b0) ^ gm13(b1) ^ gm9(b2) ^ gm14(b3);
  end

endmodule

/* logic/aes_inv_sub_word.sv */
module aes_inv_sub_word (
  input  aes_dec_pkg::block_t    state,
  input  aes_dec_pkg::word_idx_t word_idx,
  output aes_dec_pkg::block_t    result
);

  import aes_dec_pkg::*;

  // Bit offset of the chosen column, word 0 at the top
  logic [6:0] base;
  word_t      sel_word;
  word_t      sub_word;

  // (3 - word_idx) * 32
  assign base     = {~word_idx, 5'b0};
  assign sel_word = state[base +: 32];

  // One inverse S-box per byte of the column
  for (genvar i = 0; i < 4; i++)
  begin : g_sbox
    aes_inv_sbox inv_sbox_i (
      .in_byte  (sel_word[8*i +: 8]),
      .out_byte (sub_word[8*i +: 8])
    );
  end

  // Other three columns pass unchanged
  always_comb
  begin
    result             = state;
    result[base +: 32] = sub_word;
  end

endmodule

/* logic/aes_inv_sbox.sv */
module aes_inv_sbox (
  input  aes_dec_pkg::byte_t in_byte,
  output aes_dec_pkg::byte_t out_byte
);

  import aes_dec_pkg::*;

  // Inverse S-box, entry 0 leftmost
  localparam logic [0:255][7:0] INV_SBOX = {
    8'h52, 8'h09, 8'h6a, 8'hd5, 8'h30, 8'h36, 8'ha5, 8'h38,
    8'hbf, 8'h40, 8'ha3, 8'h9e, 8'h81, 8'hf3, 8'hd7, 8'hfb,
    8'h7c, 8'he3, 8'h39, 8'h82, 8'h9b, 8'h2f, 8'hff, 8'h87,
    8'h34, 8'h8e, 8'h43, 8'h44, 8'hc4, 8'hde, 8'he9, 8'hcb,
    8'h54, 8'h7b, 8'h94, 8'h32, 8'ha6, 8'hc2, 8'h23, 8'h3d,
    8'hee, 8'h4c, 8'h95, 8'h0b, 8'h42, 8'hfa, 8'hc3, 8'h4e,
    8'h08, 8'h2e, 8'ha1, 8'h66, 8'h28, 8'hd9, 8'h24, 8'hb2,
    8'h76, 8'h5b, 8'ha2, 8'h49, 8'h6d, 8'h8b, 8'hd1, 8'h25,
    8'h72, 8'hf8, 8'hf6, 8'h64, 8'h86, 8'h68, 8'h98, 8'h16,
    8'hd4, 8'ha4, 8'h5c, 8'hcc, 8'h5d, 8'h65, 8'hb6, 8'h92,
    8'h6c, 8'h70, 8'h48, 8'h50, 8'hfd, 8'hed, 8'hb9, 8'hda,
    8'h5e, 8'h15, 8'h46, 8'h57, 8'ha7, 8'h8d, 8'h9d, 8'h84,
    8'h90, 8'hd8, 8'hab, 8'h00, 8'h8c, 8'hbc, 8'hd3, 8'h0a,
    8'hf7, 8'he4, 8'h58, 8'h05, 8'hb8, 8'hb3, 8'h45, 8'h06,
    8'hd0, 8'h2c, 8'h1e, 8'h8f, 8'hca, 8'h3f, 8'h0f, 8'h02,
    8'hc1, 8'haf, 8'hbd, 8'h03, 8'h01, 8'h13, 8'h8a, 8'h6b,
    8'h3a, 8'h91, 8'h11, 8'h41, 8'h4f, 8'h67, 8'hdc, 8'hea,
    8'h97, 8'hf2, 8'hcf, 8'hce, 8'hf0, 8'hb4, 8'he6, 8'h73,
    8'h96, 8'hac, 8'h74, 8'h22, 8'he7, 8'had, 8'h35, 8'h85,
    8'he2, 8'hf9, 8'h37, 8'he8, 8'h1c, 8'h75, 8'hdf, 8'h6e,
    8'h47, 8'hf1, 8'h1a, 8'h71, 8'h1d, 8'h29, 8'hc5, 8'h89,
    8'h6f, 8'hb7, 8'h62, 8'h0e, 8'haa, 8'h18, 8'hbe, 8'h1b,
    8'hfc, 8'h56, 8'h3e, 8'h4b, 8'hc6, 8'hd2, 8'h79, 8'h20,
    8'h9a, 8'hdb, 8'hc0, 8'hfe, 8'h78, 8'hcd, 8'h5a, 8'hf4,
    8'h1f, 8'hdd, 8'ha8, 8'h33, 8'h88, 8'h07, 8'hc7, 8'h31,
    8'hb1, 8'h12, 8'h10, 8'h59, 8'h27, 8'h80, 8'hec, 8'h5f,
    8'h60, 8'h51, 8'h7f, 8'ha9, 8'h19, 8'hb5, 8'h4a, 8'h0d,
    8'h2d, 8'he5, 8'h7a, 8'h9f, 8'h93, 8'hc9, 8'h9c, 8'hef,
    8'ha0, 8'he0, 8'h3b, 8'h4d, 8'hae, 8'h2a, 8'hf5, 8'hb0,
    8'hc8, 8'heb, 8'hbb, 8'h3c, 8'h83, 8'h53, 8'h99, 8'h61,
    8'h17, 8'h2b, 8'h04, 8'h7e, 8'hba, 8'h77, 8'hd6, 8'h26,
    8'he1, 8'h69, 8'h14, 8'h63, 8'h55, 8'h21, 8'h0c, 8'h7d
  };

  // Pure lookup, no clock
  assign out_byte = byte_t'(INV_SBOX[in_byte]);

endmodule

/* logic/aes_dec_pkg.sv */
package aes_dec_pkg;

  // ----------------------------------------
  // Vector types
  // ----------------------------------------

  // Full AES state, column-major, byte 0 in bits 127:120
  typedef logic [127:0] block_t;
  // One state column
  typedef logic [31:0]  word_t;
  // GF(2^8) element
  typedef logic [7:0]   byte_t;
  // Round key index, 0 to 14
  typedef logic [3:0]   round_t;
  // Column under substitution
  typedef logic [1:0]   word_idx_t;

  // Controller steps
  typedef enum logic [2:0] {
    dec_idle,
    dec_init,
    dec_shift,
    dec_sbox,
    dec_key,
    dec_mix
  } dec_state_t;

  // Source for the next block register value
  typedef enum logic [2:0] {
    upd_hold,
    upd_init_key,
    upd_shift,
    upd_sbox,
    upd_key,
    upd_mix
  } block_upd_t;

  // ----------------------------------------
  // GF(2^8) constant multipliers
  // ----------------------------------------

  // xtime, reduction by x^8 + x^4 + x^3 + x + 1
  function automatic byte_t gm2(input byte_t b);
    return {b[6:0], 1'b0} ^ (8'h1b & {8{b[7]}});
  endfunction

  // 9 = 8 + 1
  function automatic byte_t gm9(input byte_t b);
    return gm2(gm2(gm2(b))) ^ b;
  endfunction

  // 11 = 8 + 2 + 1
  function automatic byte_t gm11(input byte_t b);
    byte_t b2;
    b2 = gm2(b);
    return gm2(gm2(b2)) ^ b2 ^ b;
  endfunction

  // 13 = 8 + 4 + 1
  function automatic byte_t gm13(input byte_t b);
    byte_t b4;
    b4 = gm2(gm2(b));
    return gm2(b4) ^ b4 ^ b;
  endfunction

  // 14 = 8 + 4 + 2
  function automatic byte_t gm14(input byte_t b);
    byte_t b2;
    byte_t b4;
    b2 = gm2(b);
    b4 = gm2(b2);
    return gm2(b4) ^ b4 ^ b2;
  endfunction

endpackage

/* logic/aes_dec_macros.svh */
`ifndef AES_DEC_MACROS_SVH
`define AES_DEC_MACROS_SVH

// ----------------------------------------
// AES round counts per key length
// ----------------------------------------

// AES-128, ten rounds
`define AES_128_ROUNDS 10

// AES-256, fourteen rounds
`define AES_256_ROUNDS 14

// InvSubBytes runs one column per cycle
`define AES_SBOX_STEPS 4

`endif
